// ==== all.f ====
design/mips_isa_pkg.sv
design/mips_pipe_pkg.sv
design/inst_decoder.sv
design/operand_bypass.sv
design/branch_resolve.sv
design/id_ex_reg.sv
design/id_stage.sv
verif/id_stage_checker.sv
verif/tb_id_stage.sv

// ==== design/branch_resolve.sv ====
`timescale 1ns/1ps

module branch_resolve
    import mips_isa_pkg::*;
    import mips_pipe_pkg::*;
(
    input  word_t    pc_i,
    input  word_t    inst_i,
    input  br_kind_t br_kind_i,
    input  word_t    opnd1_i,
    input  word_t    opnd2_i,
    output branch_t  branch_o,
    output word_t    link_addr_o,
    output logic     next_in_delayslot_o
);

    word_t pc_plus4;
    word_t br_offset;
    word_t target;
    logic  opnd1_neg;
    logic  opnd1_zero;
    logic  taken;

    assign pc_plus4   = pc_i + 32'd4;
    assign br_offset  = {{14{inst_i[15]}}, inst_i[15:0], 2'b00};
    assign opnd1_neg  = opnd1_i[31];
    assign opnd1_zero = (opnd1_i == '0);

    always_comb begin
        target = pc_plus4 + br_offset;
        case (br_kind_i)
            BR_J: begin
                taken  = 1'b1;
                target = {pc_plus4[31:28], inst_i[25:0], 2'b00};
            end
            BR_JR: begin
                taken  = 1'b1;
                target = opnd1_i;
            end
            BR_BEQ:  taken = (opnd1_i == opnd2_i);
            BR_BNE:  taken = (opnd1_i != opnd2_i);
            BR_BGTZ: taken = !opnd1_neg && !opnd1_zero;
            BR_BLEZ: taken = opnd1_neg || opnd1_zero;
            BR_BLTZ: taken = opnd1_neg;
            BR_BGEZ: taken = !opnd1_neg;
            default: taken = 1'b0;
        endcase
    end

    assign branch_o.taken  = taken;
    assign branch_o.target = taken ? target : '0;

    // return address skips the delay slot
    assign link_addr_o = pc_i + 32'd8;

    assign next_in_delayslot_o = taken;

endmodule

// ==== design/id_ex_reg.sv ====
`timescale 1ns/1ps

module id_ex_reg
    import mips_isa_pkg::*;
    import mips_pipe_pkg::*;
(
    input  logic    clk,
    input  logic    rst_i,
    input  decode_t dec_i,
    input  word_t   opnd1_i,
    input  word_t   opnd2_i,
    input  word_t   link_addr_i,
    input  logic    next_in_delayslot_i,
    input  word_t   inst_i,
    output id_ex_t  ex_o,
    output logic    stall_o
);

    id_ex_t ex_q;
    logic   ds_q;
    logic   hit1;
    logic   hit2;

    // load in EX whose result the current instruction needs
    assign hit1 = dec_i.rd1.en && (dec_i.rd1.addr == ex_q.wd);
    assign hit2 = dec_i.rd2.en && (dec_i.rd2.addr == ex_q.wd);

    assign stall_o = is_load(ex_q.aluop) && ex_q.wreg && (ex_q.wd != '0) && (hit1 || hit2);

    always_ff @(posedge clk) begin
        if (rst_i || stall_o) begin
            // bubble
            ex_q.aluop        <= ALU_NOP;
            ex_q.alusel       <= SEL_NOP;
            ex_q.wd           <= '0;
            ex_q.wreg         <= 1'b0;
            ex_q.in_delayslot <= 1'b0;
        end else begin
            ex_q.aluop        <= dec_i.aluop;
            ex_q.alusel       <= dec_i.alusel;
            ex_q.opnd1        <= opnd1_i;
            ex_q.opnd2        <= opnd2_i;
            ex_q.wd           <= dec_i.wd;
            ex_q.wreg         <= dec_i.wreg;
            ex_q.link_addr    <= dec_i.link ? link_addr_i : '0;
            ex_q.in_delayslot <= ds_q;
            ex_q.inst         <= inst_i;
        end
    end

    // delay-slot flag for the next accepted instruction
    // held across a stall so the slot instruction still sees it
    always_ff @(posedge clk) begin
        if (rst_i) begin
            ds_q <= 1'b0;
        end else if (!stall_o) begin
            ds_q <= next_in_delayslot_i;
        end
    end

    assign ex_o = ex_q;

endmodule

// ==== design/id_stage.sv ====
`timescale 1ns/1ps

module id_stage
    import mips_isa_pkg::*;
    import mips_pipe_pkg::*;
(
    input  logic    clk,
    input  logic    rst_i,
    input  word_t   pc_i,
    input  word_t   inst_i,
    input  word_t   rf_rdata1_i,
    input  word_t   rf_rdata2_i,
    input  fwd_t    ex_fwd_i,
    input  fwd_t    mem_fwd_i,
    output rd_req_t rf_req1_o,
    output rd_req_t rf_req2_o,
    output branch_t branch_o,
    output logic    stall_o,
    output id_ex_t  ex_o
);

    decode_t dec;
    word_t   opnd1;
    word_t   opnd2;
    word_t   link_addr;
    logic    next_in_delayslot;

    inst_decoder decoder (
        .inst_i (inst_i),
        .dec_o  (dec)
    );

    assign rf_req1_o = dec.rd1;
    assign rf_req2_o = dec.rd2;

    operand_bypass opnd1_sel (
        .req_i      (dec.rd1),
        .imm_i      (dec.imm),
        .rf_rdata_i (rf_rdata1_i),
        .ex_fwd_i   (ex_fwd_i),
        .mem_fwd_i  (mem_fwd_i),
        .opnd_o     (opnd1)
    );

    operand_bypass opnd2_sel (
        .req_i      (dec.rd2),
        .imm_i      (dec.imm),
        .rf_rdata_i (rf_rdata2_i),
        .ex_fwd_i   (ex_fwd_i),
        .mem_fwd_i  (mem_fwd_i),
        .opnd_o     (opnd2)
    );

    branch_resolve br_unit (
        .pc_i                (pc_i),
        .inst_i              (inst_i),
        .br_kind_i           (dec.br_kind),
        .opnd1_i             (opnd1),
        .opnd2_i             (opnd2),
        .branch_o            (branch_o),
        .link_addr_o         (link_addr),
        .next_in_delayslot_o (next_in_delayslot)
    );

    id_ex_reg pipe_reg (
        .clk                 (clk),
        .rst_i               (rst_i),
        .dec_i               (dec),
        .opnd1_i             (opnd1),
        .opnd2_i             (opnd2),
        .link_addr_i         (link_addr),
        .next_in_delayslot_i (next_in_delayslot),
        .inst_i              (inst_i),
        .ex_o                (ex_o),
        .stall_o             (stall_o)
    );

endmodule

// ==== design/inst_decoder.sv ====
`timescale 1ns/1ps

module inst_decoder
    import mips_isa_pkg::*;
    import mips_pipe_pkg::*;
(
    input  word_t   inst_i,
    output decode_t dec_o
);

    opcode_t   op;
    funct_t    fn;
    regimm_t   ri;
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t rd;
    logic [4:0] sa;
    word_t     imm_zext;
    word_t     imm_sext;
    word_t     imm_high;
    decode_t   d;

    assign op = opcode_t'(inst_i[31:26]);
    assign fn = funct_t'(inst_i[5:0]);
    assign ri = regimm_t'(inst_i[20:16]);
    assign rs = inst_i[25:21];
    assign rt = inst_i[20:16];
    assign rd = inst_i[15:11];
    assign sa = inst_i[10:6];

    assign imm_zext = {16'b0, inst_i[15:0]};
    assign imm_sext = {{16{inst_i[15]}}, inst_i[15:0]};
    assign imm_high = {inst_i[15:0], 16'b0};

    // two register reads, result to d
    function automatic decode_t rr_op(aluop_t aop, alusel_t sel, reg_addr_t a,
                                      reg_addr_t b, reg_addr_t dst);
        decode_t r;
        r = '0;
        r.aluop = aop;
        r.alusel = sel;
        r.rd1 = '{en: 1'b1, addr: a};
        r.rd2 = '{en: 1'b1, addr: b};
        r.wreg = 1'b1;
        r.wd = dst;
        return r;
    endfunction

    // rs read, immediate as second operand
    function automatic decode_t ri_op(aluop_t aop, alusel_t sel, reg_addr_t a,
                                      word_t imm, reg_addr_t dst);
        decode_t r;
        r = '0;
        r.aluop = aop;
        r.alusel = sel;
        r.rd1 = '{en: 1'b1, addr: a};
        r.imm = imm;
        r.wreg = 1'b1;
        r.wd = dst;
        return r;
    endfunction

    function automatic decode_t br_op(aluop_t aop, br_kind_t kind, logic a_en,
                                      reg_addr_t a, logic b_en, reg_addr_t b);
        decode_t r;
        r = '0;
        r.aluop = aop;
        r.alusel = SEL_JUMP_BRANCH;
        r.rd1 = '{en: a_en, addr: a};
        r.rd2 = '{en: b_en, addr: b};
        r.br_kind = kind;
        return r;
    endfunction

    always_comb begin
        d = '0;
        case (op)
            OP_SPECIAL: begin
                case (fn)
                    FN_AND:  d = rr_op(ALU_AND, SEL_LOGIC, rs, rt, rd);
                    FN_OR:   d = rr_op(ALU_OR, SEL_LOGIC, rs, rt, rd);
                    FN_XOR:  d = rr_op(ALU_XOR, SEL_LOGIC, rs, rt, rd);
                    FN_NOR:  d = rr_op(ALU_NOR, SEL_LOGIC, rs, rt, rd);
                    FN_SLLV: d = rr_op(ALU_SLL, SEL_SHIFT, rs, rt, rd);
                    FN_SRLV: d = rr_op(ALU_SRL, SEL_SHIFT, rs, rt, rd);
                    FN_SRAV: d = rr_op(ALU_SRA, SEL_SHIFT, rs, rt, rd);
                    FN_ADD:  d = rr_op(ALU_ADD, SEL_ARITH, rs, rt, rd);
                    FN_ADDU: d = rr_op(ALU_ADDU, SEL_ARITH, rs, rt, rd);
                    FN_SUB:  d = rr_op(ALU_SUB, SEL_ARITH, rs, rt, rd);
                    FN_SUBU: d = rr_op(ALU_SUBU, SEL_ARITH, rs, rt, rd);
                    FN_SLT:  d = rr_op(ALU_SLT, SEL_ARITH, rs, rt, rd);
                    FN_SLTU: d = rr_op(ALU_SLTU, SEL_ARITH, rs, rt, rd);
                    FN_SLL, FN_SRL, FN_SRA: begin
                        d = rr_op(ALU_SLL, SEL_SHIFT, rs, rt, rd);
                        if (fn == FN_SRL) begin
                            d.aluop = ALU_SRL;
                        end else if (fn == FN_SRA) begin
                            d.aluop = ALU_SRA;
                        end
                        // shift amount replaces rs
                        d.rd1 = '0;
                        d.imm = {27'b0, sa};
                    end
                    FN_JR:   d = br_op(ALU_JR, BR_JR, 1'b1, rs, 1'b0, '0);
                    FN_JALR: begin
                        d = br_op(ALU_JALR, BR_JR, 1'b1, rs, 1'b0, '0);
                        d.wreg = 1'b1;
                        d.wd = rd;
                    end
                    default: d = '0;
                endcase
            end
            OP_REGIMM: begin
                case (ri)
                    RI_BLTZ:   d = br_op(ALU_BLTZ, BR_BLTZ, 1'b1, rs, 1'b0, '0);
                    RI_BGEZ:   d = br_op(ALU_BGEZ, BR_BGEZ, 1'b1, rs, 1'b0, '0);
                    RI_BLTZAL: d = br_op(ALU_BLTZAL, BR_BLTZ, 1'b1, rs, 1'b0, '0);
                    RI_BGEZAL: d = br_op(ALU_BGEZAL, BR_BGEZ, 1'b1, rs, 1'b0, '0);
                    default:   d = '0;
                endcase
                if (ri == RI_BLTZAL || ri == RI_BGEZAL) begin
                    d.wreg = 1'b1;
                    d.wd = LINK_REG;
                end
            end
            OP_J:     d = br_op(ALU_J, BR_J, 1'b0, '0, 1'b0, '0);
            OP_JAL: begin
                d = br_op(ALU_JAL, BR_J, 1'b0, '0, 1'b0, '0);
                d.wreg = 1'b1;
                d.wd = LINK_REG;
            end
            OP_BEQ:   d = br_op(ALU_BEQ, BR_BEQ, 1'b1, rs, 1'b1, rt);
            OP_BNE:   d = br_op(ALU_BNE, BR_BNE, 1'b1, rs, 1'b1, rt);
            OP_BGTZ:  d = br_op(ALU_BGTZ, BR_BGTZ, 1'b1, rs, 1'b0, '0);
            OP_BLEZ:  d = br_op(ALU_BLEZ, BR_BLEZ, 1'b1, rs, 1'b0, '0);
            OP_ANDI:  d = ri_op(ALU_AND, SEL_LOGIC, rs, imm_zext, rt);
            OP_ORI:   d = ri_op(ALU_OR, SEL_LOGIC, rs, imm_zext, rt);
            OP_XORI:  d = ri_op(ALU_XOR, SEL_LOGIC, rs, imm_zext, rt);
            // rs is zero in a legal LUI, so OR yields the upper half
            OP_LUI:   d = ri_op(ALU_OR, SEL_LOGIC, rs, imm_high, rt);
            OP_ADDI:  d = ri_op(ALU_ADDI, SEL_ARITH, rs, imm_sext, rt);
            OP_ADDIU: d = ri_op(ALU_ADDIU, SEL_ARITH, rs, imm_sext, rt);
            OP_SLTI:  d = ri_op(ALU_SLT, SEL_ARITH, rs, imm_sext, rt);
            OP_SLTIU: d = ri_op(ALU_SLTU, SEL_ARITH, rs, imm_sext, rt);
            OP_LB:    d = ri_op(ALU_LB, SEL_LOAD_STORE, rs, imm_sext, rt);
            OP_LBU:   d = ri_op(ALU_LBU, SEL_LOAD_STORE, rs, imm_sext, rt);
            OP_LH:    d = ri_op(ALU_LH, SEL_LOAD_STORE, rs, imm_sext, rt);
            OP_LHU:   d = ri_op(ALU_LHU, SEL_LOAD_STORE, rs, imm_sext, rt);
            OP_LW:    d = ri_op(ALU_LW, SEL_LOAD_STORE, rs, imm_sext, rt);
            OP_SB, OP_SH, OP_SW: begin
                d = rr_op(ALU_SW, SEL_LOAD_STORE, rs, rt, '0);
                if (op == OP_SB) begin
                    d.aluop = ALU_SB;
                end else if (op == OP_SH) begin
                    d.aluop = ALU_SH;
                end
                // stores write memory only
                d.wreg = 1'b0;
                d.imm = imm_sext;
            end
            default:  d = '0;
        endcase
        d.link = is_link_kind(d.aluop);
    end

    assign dec_o = d;

endmodule

// ==== design/mips_isa_pkg.sv ====
package mips_isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    localparam reg_addr_t LINK_REG = 5'd31;

    // major opcode, inst[31:26]
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'b000000,
        OP_REGIMM  = 6'b000001,
        OP_J       = 6'b000010,
        OP_JAL     = 6'b000011,
        OP_BEQ     = 6'b000100,
        OP_BNE     = 6'b000101,
        OP_BLEZ    = 6'b000110,
        OP_BGTZ    = 6'b000111,
        OP_ADDI    = 6'b001000,
        OP_ADDIU   = 6'b001001,
        OP_SLTI    = 6'b001010,
        OP_SLTIU   = 6'b001011,
        OP_ANDI    = 6'b001100,
        OP_ORI     = 6'b001101,
        OP_XORI    = 6'b001110,
        OP_LUI     = 6'b001111,
        OP_LB      = 6'b100000,
        OP_LH      = 6'b100001,
        OP_LW      = 6'b100011,
        OP_LBU     = 6'b100100,
        OP_LHU     = 6'b100101,
        OP_SB      = 6'b101000,
        OP_SH      = 6'b101001,
        OP_SW      = 6'b101011
    } opcode_t;

    // SPECIAL function field, inst[5:0]
    typedef enum logic [5:0] {
        FN_SLL  = 6'b000000, FN_SRL  = 6'b000010, FN_SRA  = 6'b000011,
        FN_SLLV = 6'b000100, FN_SRLV = 6'b000110, FN_SRAV = 6'b000111,
        FN_JR   = 6'b001000, FN_JALR = 6'b001001,
        FN_ADD  = 6'b100000, FN_ADDU = 6'b100001,
        FN_SUB  = 6'b100010, FN_SUBU = 6'b100011,
        FN_AND  = 6'b100100, FN_OR   = 6'b100101,
        FN_XOR  = 6'b100110, FN_NOR  = 6'b100111,
        FN_SLT  = 6'b101010, FN_SLTU = 6'b101011
    } funct_t;

    // REGIMM branches live in the rt field
    typedef enum logic [4:0] {
        RI_BLTZ   = 5'b00000,
        RI_BGEZ   = 5'b00001,
        RI_BLTZAL = 5'b10000,
        RI_BGEZAL = 5'b10001
    } regimm_t;

endpackage

// ==== design/mips_pipe_pkg.sv ====
package mips_pipe_pkg;
    import mips_isa_pkg::*;

    // EX operation codes
    typedef enum logic [7:0] {
        ALU_NOP    = 8'b00000000,
        ALU_AND    = 8'b00100100, ALU_OR     = 8'b00100101,
        ALU_XOR    = 8'b00100110, ALU_NOR    = 8'b00100111,
        ALU_SLL    = 8'b01111100, ALU_SRL    = 8'b00000010, ALU_SRA = 8'b00000011,
        ALU_SLT    = 8'b00101010, ALU_SLTU   = 8'b00101011,
        ALU_ADD    = 8'b00100000, ALU_ADDU   = 8'b00100001,
        ALU_SUB    = 8'b00100010, ALU_SUBU   = 8'b00100011,
        ALU_ADDI   = 8'b01010101, ALU_ADDIU  = 8'b01010110,
        ALU_J      = 8'b01001111, ALU_JAL    = 8'b01010000,
        ALU_JR     = 8'b00001000, ALU_JALR   = 8'b00001001,
        ALU_BEQ    = 8'b01010001, ALU_BNE    = 8'b01010010,
        ALU_BGTZ   = 8'b01010100, ALU_BLEZ   = 8'b01010011,
        ALU_BLTZ   = 8'b01000000, ALU_BGEZ   = 8'b01000001,
        ALU_BLTZAL = 8'b01001010, ALU_BGEZAL = 8'b01001011,
        ALU_LB     = 8'b11100000, ALU_LBU    = 8'b11100100,
        ALU_LH     = 8'b11100001, ALU_LHU    = 8'b11100101, ALU_LW = 8'b11100011,
        ALU_SB     = 8'b11101000, ALU_SH     = 8'b11101001, ALU_SW = 8'b11101011
    } aluop_t;

    typedef enum logic [2:0] {
        SEL_NOP         = 3'b000,
        SEL_LOGIC       = 3'b001,
        SEL_SHIFT       = 3'b010,
        SEL_ARITH       = 3'b100,
        SEL_JUMP_BRANCH = 3'b110,
        SEL_LOAD_STORE  = 3'b111
    } alusel_t;

    typedef enum logic [3:0] {
        BR_NONE, BR_J, BR_JR, BR_BEQ, BR_BNE, BR_BGTZ, BR_BLEZ, BR_BLTZ, BR_BGEZ
    } br_kind_t;

    typedef struct packed {
        logic      en;
        reg_addr_t addr;
    } rd_req_t;

    typedef struct packed {
        logic      we;
        reg_addr_t wd;
        word_t     wdata;
    } fwd_t;

    typedef struct packed {
        aluop_t    aluop;
        alusel_t   alusel;
        rd_req_t   rd1;
        rd_req_t   rd2;
        word_t     imm;
        reg_addr_t wd;
        logic      wreg;
        br_kind_t  br_kind;
        logic      link;
    } decode_t;

    typedef struct packed {
        logic  taken;
        word_t target;
    } branch_t;

    typedef struct packed {
        aluop_t    aluop;
        alusel_t   alusel;
        word_t     opnd1;
        word_t     opnd2;
        reg_addr_t wd;
        logic      wreg;
        word_t     link_addr;
        logic      in_delayslot;
        word_t     inst;
    } id_ex_t;

    function automatic logic is_load(aluop_t op);
        return op inside {ALU_LB, ALU_LBU, ALU_LH, ALU_LHU, ALU_LW};
    endfunction

    function automatic logic is_link_kind(aluop_t op);
        return op inside {ALU_JAL, ALU_JALR, ALU_BLTZAL, ALU_BGEZAL};
    endfunction

endpackage

// ==== design/operand_bypass.sv ====
`timescale 1ns/1ps

module operand_bypass
    import mips_isa_pkg::*;
    import mips_pipe_pkg::*;
(
    input  rd_req_t req_i,
    input  word_t   imm_i,
    input  word_t   rf_rdata_i,
    input  fwd_t    ex_fwd_i,
    input  fwd_t    mem_fwd_i,
    output word_t   opnd_o
);

    logic ex_hit;
    logic mem_hit;

    // r0 is hardwired, never forward it
    assign ex_hit  = ex_fwd_i.we && (ex_fwd_i.wd == req_i.addr) && (req_i.addr != '0);
    assign mem_hit = mem_fwd_i.we && (mem_fwd_i.wd == req_i.addr) && (req_i.addr != '0);

    always_comb begin
        if (!req_i.en) begin
            opnd_o = imm_i;
        end else if (ex_hit) begin
            // youngest result wins
            opnd_o = ex_fwd_i.wdata;
        end else if (mem_hit) begin
            opnd_o = mem_fwd_i.wdata;
        end else begin
            opnd_o = rf_rdata_i;
        end
    end

endmodule

// ==== run.sh ====
#!/bin/bash
# build and run the ID stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f all.f --top-module tb_id_stage -o sim_id_stage
if [ $? -ne 0 ]; then
    echo "compile step failed"
    exit 1
fi

out=$(./obj_dir/sim_id_stage 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "TEST PASSED"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

// ==== verif/id_stage_checker.sv ====
`timescale 1ns/1ps

module id_stage_checker
    import mips_isa_pkg::*;
    import mips_pipe_pkg::*;
(
    input logic   clk,
    input logic   rst_i,
    input id_ex_t ex_o,
    input logic   stall_o
);

    // a stalled edge must load a bubble
    stall_gives_bubble: assert property (
        @(posedge clk) disable iff (rst_i)
        stall_o |=> !ex_o.wreg
    ) else $error("stall did not clear wreg on ex_o");

    // reset leaves a bubble in EX
    reset_gives_bubble: assert property (
        @(posedge clk)
        rst_i |=> (ex_o.aluop == ALU_NOP) && !ex_o.wreg && !ex_o.in_delayslot
    ) else $error("ex_o is not a bubble after reset");

    // only one slot follows a branch
    single_delayslot: assert property (
        @(posedge clk) disable iff (rst_i)
        ex_o.in_delayslot |=> !ex_o.in_delayslot
    ) else $error("in_delayslot high in two consecutive cycles");

endmodule

bind id_ex_reg id_stage_checker chk0 (
    .clk     (clk),
    .rst_i   (rst_i),
    .ex_o    (ex_o),
    .stall_o (stall_o)
);

// ==== verif/tb_id_stage.sv ====
`timescale 1ns/1ps

module tb_id_stage
    import mips_isa_pkg::*;
    import mips_pipe_pkg::*;
;

    logic    clk;
    logic    rst_i;
    word_t   pc_i;
    word_t   inst_i;
    word_t   rf_rdata1_i;
    word_t   rf_rdata2_i;
    fwd_t    ex_fwd_i;
    fwd_t    mem_fwd_i;
    rd_req_t rf_req1_o;
    rd_req_t rf_req2_o;
    branch_t branch_o;
    logic    stall_o;
    id_ex_t  ex_o;

    word_t   rf [0:31];
    integer  seed;

    id_stage dut0 (
        .clk(clk), .rst_i(rst_i), .pc_i(pc_i), .inst_i(inst_i),
        .rf_rdata1_i(rf_rdata1_i), .rf_rdata2_i(rf_rdata2_i),
        .ex_fwd_i(ex_fwd_i), .mem_fwd_i(mem_fwd_i),
        .rf_req1_o(rf_req1_o), .rf_req2_o(rf_req2_o),
        .branch_o(branch_o), .stall_o(stall_o), .ex_o(ex_o)
    );

    // register file model where r0 reads zero
    assign rf_rdata1_i = (rf_req1_o.addr == '0) ? '0 : rf[rf_req1_o.addr];
    assign rf_rdata2_i = (rf_req2_o.addr == '0) ? '0 : rf[rf_req2_o.addr];

    always #50 clk = ~clk;

    function automatic word_t rtype(reg_addr_t rs, reg_addr_t rt, reg_addr_t rd,
                                    logic [4:0] sa, logic [5:0] fn);
        return {6'b000000, rs, rt, rd, sa, fn};
    endfunction

    function automatic word_t itype(logic [5:0] op, reg_addr_t rs, reg_addr_t rt,
                                    logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t branch_target(word_t pc, logic [15:0] off);
        return pc + 32'd4 + {{14{off[15]}}, off, 2'b00};
    endfunction

    // expected aluop and alusel per register-form funct
    function automatic logic [10:0] model_decode(logic [5:0] fn);
        case (fn)
            6'h00: return {ALU_SLL, SEL_SHIFT};
            6'h02: return {ALU_SRL, SEL_SHIFT};
            6'h03: return {ALU_SRA, SEL_SHIFT};
            6'h04: return {ALU_SLL, SEL_SHIFT};
            6'h06: return {ALU_SRL, SEL_SHIFT};
            6'h07: return {ALU_SRA, SEL_SHIFT};
            6'h20: return {ALU_ADD, SEL_ARITH};
            6'h21: return {ALU_ADDU, SEL_ARITH};
            6'h22: return {ALU_SUB, SEL_ARITH};
            6'h23: return {ALU_SUBU, SEL_ARITH};
            6'h24: return {ALU_AND, SEL_LOGIC};
            6'h25: return {ALU_OR, SEL_LOGIC};
            6'h26: return {ALU_XOR, SEL_LOGIC};
            6'h27: return {ALU_NOR, SEL_LOGIC};
            6'h2a: return {ALU_SLT, SEL_ARITH};
            default: return {ALU_SLTU, SEL_ARITH};
        endcase
    endfunction

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string msg);
        if (got !== exp) begin
            $display("FAIL at %0t: %s got %h expected %h", $time, msg, got, exp);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    task automatic drive(input word_t inst, input word_t pc);
        pc_i = pc;
        inst_i = inst;
        #1;
    endtask

    task automatic clock_in;
        @(posedge clk);
        @(negedge clk);
    endtask

    task automatic check_ex(input aluop_t op, input alusel_t sel, input word_t o1,
                            input word_t o2, input reg_addr_t wd, input logic wreg,
                            input string name);
        check(ex_o.aluop, op, {name, " aluop"});
        check(ex_o.alusel, sel, {name, " alusel"});
        check(ex_o.opnd1, o1, {name, " opnd1"});
        check(ex_o.opnd2, o2, {name, " opnd2"});
        check(ex_o.wd, wd, {name, " wd"});
        check(ex_o.wreg, wreg, {name, " wreg"});
    endtask

    task automatic alu_case(input word_t inst, input aluop_t op, input alusel_t sel,
                            input word_t o1, input word_t o2, input reg_addr_t wd,
                            input string name);
        drive(inst, 32'h0000_1000);
        clock_in();
        check_ex(op, sel, o1, o2, wd, 1'b1, name);
    endtask

    task automatic test_alu_decode;
        alu_case(rtype(1, 2, 3, 0, 6'h24), ALU_AND, SEL_LOGIC, rf[1], rf[2], 3, "and");
        alu_case(rtype(1, 2, 3, 0, 6'h25), ALU_OR, SEL_LOGIC, rf[1], rf[2], 3, "or");
        alu_case(rtype(1, 2, 4, 0, 6'h26), ALU_XOR, SEL_LOGIC, rf[1], rf[2], 4, "xor");
        alu_case(rtype(1, 2, 4, 0, 6'h27), ALU_NOR, SEL_LOGIC, rf[1], rf[2], 4, "nor");
        alu_case(rtype(1, 2, 5, 0, 6'h20), ALU_ADD, SEL_ARITH, rf[1], rf[2], 5, "add");
        alu_case(rtype(2, 1, 5, 0, 6'h23), ALU_SUBU, SEL_ARITH, rf[2], rf[1], 5, "subu");
        alu_case(rtype(1, 2, 6, 0, 6'h2a), ALU_SLT, SEL_ARITH, rf[1], rf[2], 6, "slt");
        alu_case(rtype(0, 2, 7, 5, 6'h00), ALU_SLL, SEL_SHIFT, 32'd5, rf[2], 7, "sll");
        alu_case(rtype(1, 2, 7, 0, 6'h07), ALU_SRA, SEL_SHIFT, rf[1], rf[2], 7, "srav");
        alu_case(itype(6'h0c, 1, 8, 16'h8001), ALU_AND, SEL_LOGIC, rf[1], 32'h0000_8001, 8,
                 "andi");
        alu_case(itype(6'h0d, 1, 8, 16'hF0F0), ALU_OR, SEL_LOGIC, rf[1], 32'h0000_F0F0, 8,
                 "ori");
        alu_case(itype(6'h0f, 0, 9, 16'hABCD), ALU_OR, SEL_LOGIC, 32'd0, 32'hABCD_0000, 9,
                 "lui");
        alu_case(itype(6'h09, 1, 9, 16'hFFFC), ALU_ADDIU, SEL_ARITH, rf[1], 32'hFFFF_FFFC, 9,
                 "addiu");
        alu_case(itype(6'h0a, 1, 9, 16'h8000), ALU_SLT, SEL_ARITH, rf[1], 32'hFFFF_8000, 9,
                 "slti");
    endtask

    task automatic test_forwarding;
        ex_fwd_i = '{we: 1'b1, wd: 5'd1, wdata: 32'hEEEE_0001};
        mem_fwd_i = '{we: 1'b1, wd: 5'd1, wdata: 32'hDDDD_0001};
        alu_case(rtype(1, 2, 3, 0, 6'h24), ALU_AND, SEL_LOGIC, 32'hEEEE_0001, rf[2], 3,
                 "fwd ex");
        ex_fwd_i.we = 1'b0;
        alu_case(rtype(1, 2, 3, 0, 6'h24), ALU_AND, SEL_LOGIC, 32'hDDDD_0001, rf[2], 3,
                 "fwd mem");
        ex_fwd_i = '{we: 1'b1, wd: 5'd0, wdata: 32'hEEEE_0000};
        mem_fwd_i = '{we: 1'b1, wd: 5'd0, wdata: 32'hDDDD_0000};
        alu_case(rtype(0, 2, 3, 0, 6'h24), ALU_AND, SEL_LOGIC, 32'd0, rf[2], 3, "fwd r0");
        ex_fwd_i = '0;
        mem_fwd_i = '0;
    endtask

    task automatic br_case(input word_t inst, input word_t pc, input aluop_t op,
                           input logic taken, input word_t target, input logic link,
                           input string name);
        drive(inst, pc);
        check(branch_o.taken, taken, {name, " taken"});
        if (taken) begin
            check(branch_o.target, target, {name, " target"});
        end
        clock_in();
        check(ex_o.aluop, op, {name, " aluop"});
        check(ex_o.alusel, SEL_JUMP_BRANCH, {name, " alusel"});
        check(ex_o.in_delayslot, 1'b0, {name, " own delay slot"});
        check(ex_o.wreg, link, {name, " wreg"});
        if (link) begin
            check(ex_o.wd, LINK_REG, {name, " wd"});
            check(ex_o.link_addr, pc + 32'd8, {name, " link_addr"});
        end else begin
            check(ex_o.link_addr, 32'd0, {name, " link_addr"});
        end
        // slot instruction
        drive(32'd0, pc + 32'd4);
        clock_in();
        check(ex_o.in_delayslot, taken, {name, " next in_delayslot"});
    endtask

    task automatic test_branches;
        word_t pc;
        pc = 32'h1000_0100;
        rf[6] = 32'd5;
        rf[7] = 32'd5;
        rf[8] = 32'hFFFF_FFFD;
        rf[9] = 32'd0;
        rf[10] = 32'd7;
        br_case(itype(6'h04, 6, 7, 16'h0010), pc, ALU_BEQ, 1,
                branch_target(pc, 16'h0010), 0, "beq t");
        br_case(itype(6'h04, 6, 10, 16'h0010), pc, ALU_BEQ, 0, 0, 0, "beq n");
        br_case(itype(6'h05, 6, 10, 16'hFFF8), pc, ALU_BNE, 1,
                branch_target(pc, 16'hFFF8), 0, "bne t");
        br_case(itype(6'h05, 6, 7, 16'hFFF8), pc, ALU_BNE, 0, 0, 0, "bne n");
        br_case(itype(6'h07, 10, 0, 16'h0004), pc, ALU_BGTZ, 1,
                branch_target(pc, 16'h0004), 0, "bgtz t");
        br_case(itype(6'h07, 9, 0, 16'h0004), pc, ALU_BGTZ, 0, 0, 0, "bgtz n");
        br_case(itype(6'h06, 9, 0, 16'h0020), pc, ALU_BLEZ, 1,
                branch_target(pc, 16'h0020), 0, "blez t");
        br_case(itype(6'h06, 10, 0, 16'h0020), pc, ALU_BLEZ, 0, 0, 0, "blez n");
        br_case(itype(6'h01, 8, 0, 16'hFF00), pc, ALU_BLTZ, 1,
                branch_target(pc, 16'hFF00), 0, "bltz t");
        br_case(itype(6'h01, 9, 0, 16'hFF00), pc, ALU_BLTZ, 0, 0, 0, "bltz n");
        br_case(itype(6'h01, 9, 1, 16'h0040), pc, ALU_BGEZ, 1,
                branch_target(pc, 16'h0040), 0, "bgez t");
        br_case(itype(6'h01, 8, 1, 16'h0040), pc, ALU_BGEZ, 0, 0, 0, "bgez n");
        br_case(itype(6'h01, 9, 5'h11, 16'h0008), pc, ALU_BGEZAL, 1,
                branch_target(pc, 16'h0008), 1, "bgezal");
        br_case({6'h02, 26'h0123456}, pc, ALU_J, 1, {4'h1, 26'h0123456, 2'b00}, 0, "j");
        br_case(rtype(10, 0, 0, 0, 6'h08), pc, ALU_JR, 1, 32'd7, 0, "jr");
        br_case({6'h03, 26'h0000040}, pc, ALU_JAL, 1, {4'h1, 26'h0000040, 2'b00}, 1, "jal");
    endtask

    task automatic test_load_use;
        integer cnt;
        rf[11] = 32'h1357_9BDF;
        drive(itype(6'h23, 1, 11, 16'h0004), 32'h0000_2000);
        clock_in();
        check_ex(ALU_LW, SEL_LOAD_STORE, rf[1], 32'd4, 11, 1'b1, "lw");
        drive(rtype(11, 2, 12, 0, 6'h21), 32'h0000_2004);
        check(stall_o, 1'b1, "stall on load use");
        clock_in();
        check(ex_o.aluop, ALU_NOP, "bubble aluop");
        check(ex_o.wreg, 1'b0, "bubble wreg");
        cnt = 0;
        while (stall_o && cnt < 20) begin
            clock_in();
            cnt = cnt + 1;
        end
        if (stall_o) begin
            $display("timeout: stall_o never fell after the load-use bubble");
            $display("TEST FAILED");
            $fatal(1);
        end
        clock_in();
        check_ex(ALU_ADDU, SEL_ARITH, rf[11], rf[2], 12, 1'b1, "held addu");
        drive(itype(6'h2b, 1, 2, 16'h0008), 32'h0000_2008);
        check(rf_req1_o.en, 1'b1, "sw read1 en");
        check(rf_req2_o.en, 1'b1, "sw read2 en");
        clock_in();
        check_ex(ALU_SW, SEL_LOAD_STORE, rf[1], rf[2], 0, 1'b0, "sw");
        check(ex_o.inst, itype(6'h2b, 1, 2, 16'h0008), "sw inst");
    endtask

    task automatic test_random_alu;
        logic [5:0] fns [0:15];
        logic [10:0] m;
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t rd;
        logic [4:0] sa;
        logic [5:0] fn;
        word_t exp1;
        fns = '{6'h00, 6'h02, 6'h03, 6'h04, 6'h06, 6'h07, 6'h20, 6'h21,
                6'h22, 6'h23, 6'h24, 6'h25, 6'h26, 6'h27, 6'h2a, 6'h2b};
        for (int i = 1; i < 32; i++) begin
            rf[i] = $random(seed);
        end
        for (int n = 0; n < 200; n++) begin
            rs = $random(seed);
            rt = $random(seed);
            rd = $random(seed);
            sa = $random(seed);
            fn = fns[$unsigned($random(seed)) % 16];
            if (rs != 0) begin
                rf[rs] = $random(seed);
            end
            m = model_decode(fn);
            exp1 = (fn == 6'h00 || fn == 6'h02 || fn == 6'h03) ? {27'b0, sa} :
                   ((rs == 0) ? 32'd0 : rf[rs]);
            alu_case(rtype(rs, rt, rd, sa, fn), aluop_t'(m[10:3]), alusel_t'(m[2:0]), exp1,
                     (rt == 0) ? 32'd0 : rf[rt], rd, "random alu");
        end
    endtask

    task automatic test_invalid;
        drive(32'hFC00_0000, 32'h0000_3000);
        clock_in();
        check(ex_o.aluop, ALU_NOP, "bad opcode aluop");
        check(ex_o.wreg, 1'b0, "bad opcode wreg");
        drive(rtype(1, 2, 3, 0, 6'h3f), 32'h0000_3004);
        clock_in();
        check(ex_o.aluop, ALU_NOP, "bad funct aluop");
        check(ex_o.alusel, SEL_NOP, "bad funct alusel");
        check(ex_o.wreg, 1'b0, "bad funct wreg");
    endtask

    initial begin
        #1_000_000;
        $display("timeout: simulation did not finish in time");
        $display("TEST FAILED");
        $fatal(1);
    end

    initial begin
        seed = 60956;
        clk = 1'b0;
        rst_i = 1'b1;
        pc_i = '0;
        inst_i = '0;
        ex_fwd_i = '0;
        mem_fwd_i = '0;
        for (int i = 0; i < 32; i++) begin
            rf[i] = {i[7:0], 8'hA5, ~i[7:0], 8'h3C};
        end
        rf[0] = '0;
        rf[2] = 32'hFFFF_0001;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_i = 1'b0;
        check(ex_o.aluop, ALU_NOP, "reset aluop");
        check(stall_o, 1'b0, "reset stall");
        test_alu_decode();
        test_forwarding();
        test_branches();
        test_load_use();
        test_random_alu();
        test_invalid();
        $display("TEST PASSED");
        $finish;
    end

endmodule
